/* design/id_defs.svh */
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// data and instruction word width
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

`define PC_STEP 4 // link = pc + 4

`endif

/* design/riscv_isa_pkg.sv */
`include "id_defs.svh"

package riscv_isa_pkg;

    // major opcodes still decoded by this stage
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000, // also jalr
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101, // bit 30 picks arithmetic
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        funct3_e               funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [`REG_ADDR_W-1:0] rs1;
        funct3_e               funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } i_fmt_t;

    // shared by lui and jal where jal scrambles the bits
    typedef struct packed {
        logic [19:0]           imm20;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } inst_u;

endpackage

/* design/id_stage_pkg.sv */
`include "id_defs.svh"

package id_stage_pkg;

    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_AND  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_JAL  = 4'd11,
        ALU_JALR = 4'd12
    } alu_op_e;

    // which result group ex returns
    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_MATH  = 3'd3,
        SEL_JUMP  = 3'd4
    } alu_sel_e;

    typedef struct packed {
        alu_op_e                alu_op;
        alu_sel_e               alu_sel;
        logic                   wreg;
        logic [`REG_ADDR_W-1:0] wd;
        logic                   valid;
    } dec_ctrl_t;

    typedef struct packed {
        logic                   re;
        logic [`REG_ADDR_W-1:0] addr;
    } rd_req_t;

    // pending write from ex or mem
    typedef struct packed {
        logic                   wreg;
        logic [`REG_ADDR_W-1:0] wd;
        logic [`XLEN-1:0]       wdata;
    } fwd_t;

    typedef struct packed {
        dec_ctrl_t        ctrl;
        logic [`XLEN-1:0] op1;
        logic [`XLEN-1:0] op2;
        logic [`XLEN-1:0] link_pc;
    } id_ex_t;

endpackage

/* design/id_decoder.sv */
`timescale 1ns/1ns
`include "id_defs.svh"

module id_decoder (
    input  riscv_isa_pkg::inst_u    inst_i,
    input  logic [`XLEN-1:0]        pc_i,
    output id_stage_pkg::dec_ctrl_t ctrl_o,
    output id_stage_pkg::rd_req_t   rs1_o,
    output id_stage_pkg::rd_req_t   rs2_o,
    output logic [`XLEN-1:0]        imm_o,
    output logic [`XLEN-1:0]        link_pc_o
);
    import riscv_isa_pkg::*;
    import id_stage_pkg::*;

    logic             is_op;
    logic             std_f7;
    logic             alt_f7;
    logic             illegal;
    logic [`XLEN-1:0] imm_i_sext;
    logic [`XLEN-1:0] imm_i_zext;
    logic [`XLEN-1:0] imm_shamt;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign is_op  = inst_i.r.opcode == OPC_OP;
    assign std_f7 = inst_i.r.funct7 == 7'b0000000;
    assign alt_f7 = inst_i.r.funct7 == 7'b0100000;

    assign imm_i_sext = {{(`XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
    assign imm_i_zext = {{(`XLEN-12){1'b0}}, inst_i.i.imm12};
    assign imm_shamt  = {{(`XLEN-`REG_ADDR_W){1'b0}}, inst_i.r.rs2}; // shamt in rs2 slot
    assign imm_u      = {inst_i.u.imm20, 12'h000};
    // j immediate bits sit as imm[20|10:1|11|19:12]
    assign imm_j      = {{12{inst_i.u.imm20[19]}}, inst_i.u.imm20[7:0],
                         inst_i.u.imm20[8], inst_i.u.imm20[18:9], 1'b0};

    always_comb
    begin
        ctrl_o    = '0;
        rs1_o     = '0;
        rs2_o     = '0;
        imm_o     = '0;
        link_pc_o = '0;
        illegal   = 1'b0;
        case (inst_i.r.opcode)
            OPC_OP, OPC_OP_IMM:
            begin
                ctrl_o.wreg  = 1'b1;
                ctrl_o.wd    = inst_i.r.rd;
                ctrl_o.valid = 1'b1;
                rs1_o        = '{re: 1'b1, addr: inst_i.r.rs1};
                if (is_op)
                begin
                    rs2_o = '{re: 1'b1, addr: inst_i.r.rs2};
                end
                imm_o   = imm_i_sext;
                illegal = is_op && !std_f7;
                case (inst_i.r.funct3)
                    F3_ADD_SUB:
                    begin
                        ctrl_o.alu_op  = (is_op && alt_f7) ? ALU_SUB : ALU_ADD;
                        ctrl_o.alu_sel = SEL_MATH;
                        illegal        = is_op && !std_f7 && !alt_f7;
                    end
                    F3_SLT:
                    begin
                        ctrl_o.alu_op  = ALU_SLT;
                        ctrl_o.alu_sel = SEL_MATH;
                    end
                    F3_SLTU:
                    begin
                        ctrl_o.alu_op  = ALU_SLTU;
                        ctrl_o.alu_sel = SEL_MATH;
                    end
                    F3_XOR:
                    begin
                        ctrl_o.alu_op  = ALU_XOR;
                        ctrl_o.alu_sel = SEL_LOGIC;
                        imm_o          = imm_i_zext;
                    end
                    F3_OR:
                    begin
                        ctrl_o.alu_op  = ALU_OR;
                        ctrl_o.alu_sel = SEL_LOGIC;
                        imm_o          = imm_i_zext;
                    end
                    F3_AND:
                    begin
                        ctrl_o.alu_op  = ALU_AND;
                        ctrl_o.alu_sel = SEL_LOGIC;
                        imm_o          = imm_i_zext;
                    end
                    F3_SLL:
                    begin
                        ctrl_o.alu_op  = ALU_SLL;
                        ctrl_o.alu_sel = SEL_SHIFT;
                        imm_o          = imm_shamt;
                        illegal        = !std_f7;
                    end
                    F3_SRL_SRA:
                    begin
                        ctrl_o.alu_op  = alt_f7 ? ALU_SRA : ALU_SRL; // bit 30
                        ctrl_o.alu_sel = SEL_SHIFT;
                        imm_o          = imm_shamt;
                        illegal        = !std_f7 && !alt_f7;
                    end
                endcase
                if (is_op)
                begin
                    imm_o = '0; // both operands come from registers
                end
            end
            OPC_LUI:
            begin
                // x0 + upper immediate through the or path
                ctrl_o = '{alu_op: ALU_OR, alu_sel: SEL_LOGIC, wreg: 1'b1,
                           wd: inst_i.u.rd, valid: 1'b1};
                rs1_o  = '{re: 1'b1, addr: '0};
                imm_o  = imm_u;
            end
            OPC_JAL:
            begin
                ctrl_o    = '{alu_op: ALU_JAL, alu_sel: SEL_JUMP, wreg: 1'b1,
                              wd: inst_i.u.rd, valid: 1'b1};
                imm_o     = imm_j;
                link_pc_o = pc_i + `PC_STEP;
            end
            OPC_JALR:
            begin
                ctrl_o    = '{alu_op: ALU_JALR, alu_sel: SEL_JUMP, wreg: 1'b1,
                              wd: inst_i.i.rd, valid: 1'b1};
                rs1_o     = '{re: 1'b1, addr: inst_i.i.rs1};
                imm_o     = imm_i_sext;
                link_pc_o = pc_i + `PC_STEP;
                illegal   = inst_i.i.funct3 != F3_ADD_SUB;
            end
            default:
            begin
                illegal = 1'b1;
            end
        endcase
        if (illegal)
        begin
            ctrl_o    = '0; // squash to a nop
            rs1_o     = '0;
            rs2_o     = '0;
            imm_o     = '0;
            link_pc_o = '0;
        end
    end

endmodule

/* design/id_regfile.sv */
`timescale 1ns/1ns
`include "id_defs.svh"

module id_regfile (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  id_stage_pkg::rd_req_t  rs1_i,
    input  id_stage_pkg::rd_req_t  rs2_i,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we_i && waddr_i != '0) // x0 is hardwired
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // a same-cycle write shows up only in the next cycle
    assign rs1_data_o = rs1_i.re ? regs[rs1_i.addr] : '0;
    assign rs2_data_o = rs2_i.re ? regs[rs2_i.addr] : '0;

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((rs1_i.addr == '0) -> (rs1_data_o == '0)) &&
        ((rs2_i.addr == '0) -> (rs2_data_o == '0)))
        else $error("id_regfile: nonzero read from x0");

endmodule

/* design/id_operand_stage.sv */
`timescale 1ns/1ns
`include "id_defs.svh"

module id_operand_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  id_stage_pkg::dec_ctrl_t ctrl_i,
    input  id_stage_pkg::rd_req_t   rs1_i,
    input  id_stage_pkg::rd_req_t   rs2_i,
    input  logic [`XLEN-1:0]        imm_i,
    input  logic [`XLEN-1:0]        link_pc_i,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`XLEN-1:0]        rs2_data_i,
    input  id_stage_pkg::fwd_t      ex_fwd_i,
    input  id_stage_pkg::fwd_t      mem_fwd_i,
    output id_stage_pkg::id_ex_t    id_ex_o
);
    import id_stage_pkg::*;

    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;

    // ex first, then mem, then the register file; x0 never forwarded
    function automatic logic [`XLEN-1:0] pick_operand(
        input rd_req_t          req,
        input logic [`XLEN-1:0] rf_data,
        input logic [`XLEN-1:0] imm,
        input fwd_t             ex_fwd,
        input fwd_t             mem_fwd
    );
        if (!req.re)
        begin
            return imm;
        end
        if (req.addr != '0 && ex_fwd.wreg && ex_fwd.wd == req.addr)
        begin
            return ex_fwd.wdata;
        end
        if (req.addr != '0 && mem_fwd.wreg && mem_fwd.wd == req.addr)
        begin
            return mem_fwd.wdata;
        end
        return rf_data;
    endfunction

    assign op1 = pick_operand(rs1_i, rs1_data_i, imm_i, ex_fwd_i, mem_fwd_i);
    assign op2 = pick_operand(rs2_i, rs2_data_i, imm_i, ex_fwd_i, mem_fwd_i);

    // id/ex register
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            id_ex_o <= '0;
        end
        else
        begin
            id_ex_o <= '{ctrl: ctrl_i, op1: op1, op2: op2, link_pc: link_pc_i};
        end
    end

    a_invalid_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        !ctrl_i.valid |=> !id_ex_o.ctrl.wreg)
        else $error("id_operand_stage: invalid word carries a register write");

endmodule

/* design/id_stage_top.sv */
`timescale 1ns/1ns
`include "id_defs.svh"

module id_stage_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  logic [`XLEN-1:0]       inst_i,
    input  id_stage_pkg::fwd_t     ex_fwd_i,
    input  id_stage_pkg::fwd_t     mem_fwd_i,
    input  logic                   rf_we_i,
    input  logic [`REG_ADDR_W-1:0] rf_waddr_i,
    input  logic [`XLEN-1:0]       rf_wdata_i,
    output id_stage_pkg::id_ex_t   id_ex_o
);
    import id_stage_pkg::*;

    dec_ctrl_t        dec_ctrl;
    rd_req_t          rs1_req;
    rd_req_t          rs2_req;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] link_pc;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;

    id_decoder u_decoder (
        .inst_i    (inst_i),
        .pc_i      (pc_i),
        .ctrl_o    (dec_ctrl),
        .rs1_o     (rs1_req),
        .rs2_o     (rs2_req),
        .imm_o     (imm),
        .link_pc_o (link_pc)
    );

    id_regfile u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (rs1_req),
        .rs2_i      (rs2_req),
        .we_i       (rf_we_i),
        .waddr_i    (rf_waddr_i),
        .wdata_i    (rf_wdata_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    id_operand_stage u_operand_stage (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ctrl_i     (dec_ctrl),
        .rs1_i      (rs1_req),
        .rs2_i      (rs2_req),
        .imm_i      (imm),
        .link_pc_i  (link_pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .id_ex_o    (id_ex_o)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    localparam int HALF_PERIOD = 5; // 10 ns clock
    localparam int RESET_CYCLES = 10;

    initial
    begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial
    begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* testbench/id_stage_tb.sv */
`timescale 1ns/1ns
`include "id_defs.svh"

module id_stage_tb;
    import riscv_isa_pkg::*;
    import id_stage_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       inst;
    fwd_t                   ex_fwd;
    fwd_t                   mem_fwd;
    logic                   rf_we;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    logic [`XLEN-1:0]       rf_wdata;
    id_ex_t                 id_ex;

    logic [`XLEN-1:0] rf_model [`NUM_REGS]; // what the write port has stored
    int               seed;
    int               errors;
    int               tests_run;
    int               tests_failed;

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    id_stage_top DUT (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .pc_i       (pc),
        .inst_i     (inst),
        .ex_fwd_i   (ex_fwd),
        .mem_fwd_i  (mem_fwd),
        .rf_we_i    (rf_we),
        .rf_waddr_i (rf_waddr),
        .rf_wdata_i (rf_wdata),
        .id_ex_o    (id_ex)
    );

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
        input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // scatter a byte offset into the jal word
    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic dec_ctrl_t valid_ctrl(input alu_op_e op, input alu_sel_e sel,
        input logic [4:0] rd);
        dec_ctrl_t c;
        c.alu_op  = op;
        c.alu_sel = sel;
        c.wreg    = 1'b1;
        c.wd      = rd;
        c.valid   = 1'b1;
        return c;
    endfunction

    task automatic check_ctrl(input string name, input dec_ctrl_t got, input dec_ctrl_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
        input logic [`XLEN-1:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // drive one instruction and sample the bundle mid-cycle after the capturing edge
    task automatic issue(input logic [31:0] word, input logic [31:0] pc_val,
        input fwd_t ex_f, input fwd_t mem_f);
        @(posedge clk);
        inst    <= word;
        pc      <= pc_val;
        ex_fwd  <= ex_f;
        mem_fwd <= mem_f;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic expect_out(input dec_ctrl_t c, input logic [31:0] op1,
        input logic [31:0] op2, input logic [31:0] link);
        check_ctrl("id_ex_o.ctrl", id_ex.ctrl, c);
        check_word("id_ex_o.op1", id_ex.op1, op1);
        check_word("id_ex_o.op2", id_ex.op2, op2);
        check_word("id_ex_o.link_pc", id_ex.link_pc, link);
    endtask

    task automatic test_reset();
        int err0;
        int cycles;
        err0   = errors;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 40)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1)
        begin
            errors++;
            $display("reset was never released within 40 cycles");
        end
        expect_out('0, '0, '0, '0);
        end_test("reset", err0);
    endtask

    task automatic preload_regs();
        int          i;
        logic [31:0] v;
        for (i = 0; i < `NUM_REGS; i++)
        begin
            v           = $random(seed);
            rf_model[i] = (i == 0) ? '0 : v; // x0 drops the write
            @(posedge clk);
            rf_we    <= 1'b1;
            rf_waddr <= i[4:0];
            rf_wdata <= v;
        end
        @(posedge clk);
        rf_we <= 1'b0;
    endtask

    task automatic do_rr(input logic [6:0] f7, input logic [2:0] f3, input alu_op_e op,
        input alu_sel_e sel, input logic [4:0] rs1, input logic [4:0] rs2,
        input logic [4:0] rd);
        issue(enc_r(f7, rs2, rs1, f3, rd, OPC_OP), 32'h100, '0, '0);
        expect_out(valid_ctrl(op, sel, rd), rf_model[rs1], rf_model[rs2], '0);
    endtask

    task automatic test_reg_reg();
        int err0;
        err0 = errors;
        do_rr(7'h00, F3_ADD_SUB, ALU_ADD, SEL_MATH, 5'd1, 5'd30, 5'd10);
        do_rr(7'h20, F3_ADD_SUB, ALU_SUB, SEL_MATH, 5'd2, 5'd29, 5'd11);
        do_rr(7'h00, F3_SLT, ALU_SLT, SEL_MATH, 5'd3, 5'd28, 5'd12);
        do_rr(7'h00, F3_SLTU, ALU_SLTU, SEL_MATH, 5'd4, 5'd27, 5'd13);
        do_rr(7'h00, F3_XOR, ALU_XOR, SEL_LOGIC, 5'd5, 5'd26, 5'd14);
        do_rr(7'h00, F3_OR, ALU_OR, SEL_LOGIC, 5'd6, 5'd25, 5'd15);
        do_rr(7'h00, F3_AND, ALU_AND, SEL_LOGIC, 5'd7, 5'd24, 5'd16);
        do_rr(7'h00, F3_SLL, ALU_SLL, SEL_SHIFT, 5'd8, 5'd23, 5'd17);
        do_rr(7'h00, F3_SRL_SRA, ALU_SRL, SEL_SHIFT, 5'd9, 5'd22, 5'd18);
        do_rr(7'h20, F3_SRL_SRA, ALU_SRA, SEL_SHIFT, 5'd31, 5'd0, 5'd19); // rs2 = x0
        end_test("reg_reg", err0);
    endtask

    task automatic do_imm(input logic [2:0] f3, input logic [11:0] imm, input alu_op_e op,
        input alu_sel_e sel, input logic [4:0] rs1, input logic [31:0] exp_op2);
        issue(enc_i(imm, rs1, f3, 5'd20, OPC_OP_IMM), 32'h200, '0, '0);
        expect_out(valid_ctrl(op, sel, 5'd20), rf_model[rs1], exp_op2, '0);
    endtask

    task automatic test_imm_ops();
        int err0;
        err0 = errors;
        do_imm(F3_ADD_SUB, 12'hFFB, ALU_ADD, SEL_MATH, 5'd1, 32'hFFFF_FFFB);
        do_imm(F3_SLT, 12'h800, ALU_SLT, SEL_MATH, 5'd2, 32'hFFFF_F800);
        do_imm(F3_SLTU, 12'hFFF, ALU_SLTU, SEL_MATH, 5'd3, 32'hFFFF_FFFF);
        do_imm(F3_XOR, 12'hF0F, ALU_XOR, SEL_LOGIC, 5'd4, 32'h0000_0F0F); // zero extended
        do_imm(F3_OR, 12'h800, ALU_OR, SEL_LOGIC, 5'd5, 32'h0000_0800);
        do_imm(F3_AND, 12'hFFF, ALU_AND, SEL_LOGIC, 5'd6, 32'h0000_0FFF);
        do_imm(F3_SLL, 12'h007, ALU_SLL, SEL_SHIFT, 5'd7, 32'd7);
        do_imm(F3_SRL_SRA, 12'h01F, ALU_SRL, SEL_SHIFT, 5'd8, 32'd31);
        do_imm(F3_SRL_SRA, 12'h40D, ALU_SRA, SEL_SHIFT, 5'd9, 32'd13);
        end_test("imm_ops", err0);
    endtask

    task automatic test_forwarding();
        int          err0;
        fwd_t        ex_f;
        fwd_t        mem_f;
        logic [31:0] add_w;
        dec_ctrl_t   add_c;
        err0  = errors;
        add_w = enc_r(7'h00, 5'd6, 5'd5, F3_ADD_SUB, 5'd3, OPC_OP);
        add_c = valid_ctrl(ALU_ADD, SEL_MATH, 5'd3);
        // ex and mem both hit rs1
        ex_f  = '{wreg: 1'b1, wd: 5'd5, wdata: 32'hAAAA_0001};
        mem_f = '{wreg: 1'b1, wd: 5'd5, wdata: 32'hBBBB_0002};
        issue(add_w, 32'h300, ex_f, mem_f);
        expect_out(add_c, 32'hAAAA_0001, rf_model[6], '0);
        // mem hits rs2, ex misses
        ex_f  = '{wreg: 1'b1, wd: 5'd7, wdata: 32'hAAAA_0003};
        mem_f = '{wreg: 1'b1, wd: 5'd6, wdata: 32'hBBBB_0004};
        issue(add_w, 32'h304, ex_f, mem_f);
        expect_out(add_c, rf_model[5], 32'hBBBB_0004, '0);
        // matching address but no write
        ex_f  = '{wreg: 1'b0, wd: 5'd5, wdata: 32'hAAAA_0005};
        mem_f = '0;
        issue(add_w, 32'h308, ex_f, mem_f);
        expect_out(add_c, rf_model[5], rf_model[6], '0);
        // x0 is never forwarded
        ex_f  = '{wreg: 1'b1, wd: 5'd0, wdata: 32'hAAAA_0006};
        mem_f = '{wreg: 1'b1, wd: 5'd0, wdata: 32'hBBBB_0007};
        issue(enc_r(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd3, OPC_OP), 32'h30C, ex_f, mem_f);
        expect_out(add_c, '0, '0, '0);
        end_test("forwarding", err0);
    endtask

    task automatic do_jal(input logic [20:0] off, input logic [31:0] pc_val);
        logic [31:0] imm;
        imm = {{11{off[20]}}, off};
        issue(enc_j(off, 5'd1), pc_val, '0, '0);
        expect_out(valid_ctrl(ALU_JAL, SEL_JUMP, 5'd1), imm, imm, pc_val + 32'd4);
    endtask

    task automatic test_upper_jump();
        int err0;
        err0 = errors;
        issue({20'hABCDE, 5'd9, 7'b0110111}, 32'h400, '0, '0);
        expect_out(valid_ctrl(ALU_OR, SEL_LOGIC, 5'd9), '0, 32'hABCD_E000, '0);
        do_jal(21'h1ABCDE, 32'h0000_1000);
        do_jal(21'h000FFE, 32'h0000_2000);
        do_jal(21'h0FF000, 32'hFFFF_FFFC); // link wraps
        issue(enc_i(12'hFF0, 5'd7, F3_ADD_SUB, 5'd2, OPC_JALR), 32'h3000, '0, '0);
        expect_out(valid_ctrl(ALU_JALR, SEL_JUMP, 5'd2), rf_model[7], 32'hFFFF_FFF0,
            32'h3004);
        end_test("upper_jump", err0);
    endtask

    task automatic test_invalid();
        int          err0;
        int          i;
        logic [31:0] bad [8];
        err0   = errors;
        bad[0] = enc_i(12'h004, 5'd1, 3'b010, 5'd3, 7'b0000011); // load
        bad[1] = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0, 7'b1100011); // branch
        bad[2] = {20'h12345, 5'd4, 7'b0010111}; // auipc
        bad[3] = 32'hFFFF_FFFF;
        bad[4] = enc_i(12'h010, 5'd7, 3'b001, 5'd2, OPC_JALR);
        bad[5] = enc_r(7'b0000001, 5'd2, 5'd1, F3_ADD_SUB, 5'd3, OPC_OP);
        bad[6] = enc_i(12'h405, 5'd1, F3_SLL, 5'd3, OPC_OP_IMM);
        bad[7] = enc_r(7'b0100000, 5'd2, 5'd1, F3_AND, 5'd3, OPC_OP);
        for (i = 0; i < 8; i++)
        begin
            issue(bad[i], 32'h500, '0, '0);
            expect_out('0, '0, '0, '0);
        end
        end_test("invalid", err0);
    endtask

    initial
    begin
        seed         = 32'h3007;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        pc           = '0;
        inst         = enc_i(12'h001, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM); // valid while in reset
        ex_fwd       = '0;
        mem_fwd      = '0;
        rf_we        = 1'b0;
        rf_waddr     = '0;
        rf_wdata     = '0;

        test_reset();
        preload_regs();
        test_reg_reg();
        test_imm_ops();
        test_forwarding();
        test_upper_jump();
        test_invalid();

        $display("tests run %0d, tests failed %0d, check errors %0d",
            tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/riscv_isa_pkg.sv
design/id_stage_pkg.sv
design/id_decoder.sv
design/id_regfile.sv
design/id_operand_stage.sv
design/id_stage_top.sv
testbench/tb_clock_gen.sv
testbench/id_stage_tb.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - design
    files:
      - design/riscv_isa_pkg.sv
      - design/id_stage_pkg.sv
      - design/id_decoder.sv
      - design/id_regfile.sv
      - design/id_operand_stage.sv
      - design/id_stage_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clock_gen.sv
      - testbench/id_stage_tb.sv
